// ==== include/zigzag_order.svh ====
// zigzag_pos function, natural 8x8 index to zigzag scan position
`ifndef ZIGZAG_ORDER_SVH
`define ZIGZAG_ORDER_SVH

// rows 4..7 are the point mirror of rows 0..3, so only 32 entries are stored
function automatic jpeg_coef_pkg::idx_t zigzag_pos(input jpeg_coef_pkg::idx_t nat);
    logic [4:0] half; // index folded into rows 0..3
    logic [5:0] zz;   // position for the folded index
    half = nat[5] ? ~nat[4:0] : nat[4:0]; // 63-n for lower half
    case (half)
        5'd0:  zz = 6'd0;  // row 0
        5'd1:  zz = 6'd1;
        5'd2:  zz = 6'd5;
        5'd3:  zz = 6'd6;
        5'd4:  zz = 6'd14;
        5'd5:  zz = 6'd15;
        5'd6:  zz = 6'd27;
        5'd7:  zz = 6'd28;
        5'd8:  zz = 6'd2;  // row 1
        5'd9:  zz = 6'd4;
        5'd10: zz = 6'd7;
        5'd11: zz = 6'd13;
        5'd12: zz = 6'd16;
        5'd13: zz = 6'd26;
        5'd14: zz = 6'd29;
        5'd15: zz = 6'd42;
        5'd16: zz = 6'd3;  // row 2
        5'd17: zz = 6'd8;
        5'd18: zz = 6'd12;
        5'd19: zz = 6'd17;
        5'd20: zz = 6'd25;
        5'd21: zz = 6'd30;
        5'd22: zz = 6'd41;
        5'd23: zz = 6'd43;
        5'd24: zz = 6'd9;  // row 3
        5'd25: zz = 6'd11;
        5'd26: zz = 6'd18;
        5'd27: zz = 6'd24;
        5'd28: zz = 6'd31;
        5'd29: zz = 6'd40;
        5'd30: zz = 6'd44;
        5'd31: zz = 6'd53;
    endcase
    zigzag_pos = nat[5] ? ~zz : zz; // 63-z for mirrored half
endfunction

`endif

// ==== hdl/jpeg_coef_pkg.sv ====
// coefficient, dc, magnitude, reciprocal and index widths with their typedefs
`default_nettype none

package jpeg_coef_pkg;

    localparam int coef_w  = 13; // signed dct coefficient
    localparam int dc_w    = 9;  // signed block average, 8 coef steps per unit
    localparam int qval_w  = 13; // signed quantized result
    localparam int mag_w   = 12; // unsigned magnitude
    localparam int recip_w = 16; // reciprocal, 1.0 = 2**16
    localparam int idx_w   = 6;  // position inside 8x8 block

    localparam int block_len = 64; // coefficients per block

    typedef logic signed [coef_w-1:0]  coef_t;
    typedef logic signed [dc_w-1:0]    dc_t;
    typedef logic signed [qval_w-1:0]  qval_t;
    typedef logic        [mag_w-1:0]   mag_t;
    typedef logic        [recip_w-1:0] recip_t;
    typedef logic        [idx_w-1:0]   idx_t;

    localparam idx_t last_idx = idx_t'(block_len - 1); // index of coefficient 63
    localparam mag_t mag_max  = '1;                    // 4095, clamp for magnitudes

endpackage

`default_nettype wire

// ==== hdl/quant_ctrl_pkg.sv ====
// table select, component type, table address, descriptor queue and latency constants
`default_nettype none

package quant_ctrl_pkg;

    localparam int tsel_w     = 3;  // eight quality tables
    localparam int table_aw   = 10; // {tsel, ctype, natural index}
    localparam int table_words = 1 << table_aw;

    typedef logic [tsel_w-1:0]   tsel_t;
    typedef logic                ctype_t; // 0 luma, 1 chroma
    typedef logic [table_aw-1:0] taddr_t;

    localparam int desc_depth = 8;                   // descriptors waiting at most
    localparam int desc_ptr_w = $clog2(desc_depth);  // circular pointer width
    localparam int desc_cnt_w = desc_ptr_w + 1;      // count holds 0..desc_depth

    localparam logic [desc_cnt_w-1:0] desc_full = desc_cnt_w'(desc_depth);

    localparam int dp_latency = 4; // coef_in to q_stb, table read included

endpackage

`default_nettype wire

// ==== hdl/block_desc_queue.sv ====
// block_desc_queue, circular store of per-block dc, component type, table and first flags
`timescale 1ns/1ps
`default_nettype none

module block_desc_queue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   desc_stb,   // push one descriptor
    input  jpeg_coef_pkg::dc_t     desc_dc,
    input  quant_ctrl_pkg::ctype_t desc_ctype,
    input  quant_ctrl_pkg::tsel_t  desc_tsel,
    input  logic                   desc_first,
    input  logic                   pop,        // block start
    output jpeg_coef_pkg::dc_t     head_dc,    // held for the whole block
    output quant_ctrl_pkg::ctype_t head_ctype,
    output quant_ctrl_pkg::tsel_t  head_tsel,
    output logic                   head_first,
    output logic                   empty
);

    logic [quant_ctrl_pkg::desc_ptr_w-1:0] wr_ptr;
    logic [quant_ctrl_pkg::desc_ptr_w-1:0] rd_ptr;
    logic [quant_ctrl_pkg::desc_cnt_w-1:0] count;
    logic                                  full;

    jpeg_coef_pkg::dc_t     dc_mem    [quant_ctrl_pkg::desc_depth];
    quant_ctrl_pkg::ctype_t ctype_mem [quant_ctrl_pkg::desc_depth];
    quant_ctrl_pkg::tsel_t  tsel_mem  [quant_ctrl_pkg::desc_depth];
    logic                   first_mem [quant_ctrl_pkg::desc_depth];

    assign empty = (count == '0);
    assign full  = (count == quant_ctrl_pkg::desc_full);

    always_ff @(posedge clk) begin
        if (desc_stb) begin // entry storage
            dc_mem[wr_ptr]    <= desc_dc;
            ctype_mem[wr_ptr] <= desc_ctype;
            tsel_mem[wr_ptr]  <= desc_tsel;
            first_mem[wr_ptr] <= desc_first;
        end
        if (pop) begin // head register, stable until next start
            head_dc    <= dc_mem[rd_ptr];
            head_ctype <= ctype_mem[rd_ptr];
            head_tsel  <= tsel_mem[rd_ptr];
            head_first <= first_mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (desc_stb) wr_ptr <= wr_ptr + 1'b1; // wraps at depth
            if (pop)      rd_ptr <= rd_ptr + 1'b1;
            case ({desc_stb, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    // a ninth waiting descriptor would overwrite the oldest
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        desc_stb && !pop |-> !full)
        else $error("descriptor queue overflow");

    // every block needs its descriptor queued first
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty)
        else $error("block start with no descriptor queued");

endmodule

`default_nettype wire

// ==== hdl/quant_table_ram.sv ====
// quant_table_ram, 1024 x 16 reciprocal store, strobed write and registered read
`timescale 1ns/1ps
`default_nettype none

module quant_table_ram (
    input  logic                   clk,
    input  logic                   tw_stb,  // write one reciprocal
    input  quant_ctrl_pkg::taddr_t tw_addr, // {tsel, ctype, natural index}
    input  jpeg_coef_pkg::recip_t  tw_data,
    input  quant_ctrl_pkg::taddr_t rd_addr, // from datapath stage 1
    output jpeg_coef_pkg::recip_t  rd_data  // one cycle after rd_addr
);

    // 8 tables x 2 component types x 64 entries
    jpeg_coef_pkg::recip_t mem [quant_ctrl_pkg::table_words];

    always_ff @(posedge clk) begin
        if (tw_stb) begin
            mem[tw_addr] <= tw_data; // host side
        end
    end

    // read register, part of the datapath latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== hdl/quant_datapath.sv ====
// quant_datapath, input counter, table address, dc restore, reciprocal multiply, rounding
`timescale 1ns/1ps
`default_nettype none

module quant_datapath (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   block_start, // with coefficient 0
    input  jpeg_coef_pkg::coef_t   coef_in,     // transposed order
    input  jpeg_coef_pkg::dc_t     blk_dc,      // valid from cycle after start
    input  quant_ctrl_pkg::ctype_t blk_ctype,
    input  quant_ctrl_pkg::tsel_t  blk_tsel,
    output quant_ctrl_pkg::taddr_t rd_addr,
    input  jpeg_coef_pkg::recip_t  rd_data,
    output logic                   q_stb,
    output jpeg_coef_pkg::idx_t    q_idx,       // natural order index
    output jpeg_coef_pkg::qval_t   q_val
);

    localparam int lat = quant_ctrl_pkg::dp_latency;
    localparam int sum_w = jpeg_coef_pkg::coef_w + 1; // coef plus 8*dc
    localparam int abs_w = sum_w - 1;                 // |sum| reaches 6144
    localparam int prod_w = abs_w + jpeg_coef_pkg::recip_w;

    logic                in_busy;   // coefficients 1..63 still due
    jpeg_coef_pkg::idx_t in_cnt;    // next input index
    jpeg_coef_pkg::idx_t cur_idx;   // input index this cycle
    logic                in_stb;

    logic                stb_pipe [lat];
    jpeg_coef_pkg::idx_t idx_pipe [lat]; // natural index alongside data

    jpeg_coef_pkg::coef_t s1_coef;
    logic signed [sum_w-1:0] dc_x8;
    logic signed [sum_w-1:0] s1_sum;
    logic        [sum_w-1:0] s1_abs;
    logic                    s2_sign;
    logic        [abs_w-1:0] s2_mag;
    logic                    s3_sign;
    logic [prod_w-1:0]       s3_prod;
    logic [prod_w:0]         rnd_sum;
    logic [prod_w-16:0]      rnd_q;
    jpeg_coef_pkg::mag_t     q_mag;

    assign in_stb  = block_start | in_busy;
    assign cur_idx = block_start ? '0 : in_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_busy <= 1'b0;
            in_cnt  <= '0;
        end else if (block_start) begin
            in_busy <= 1'b1;
            in_cnt  <= 6'd1;
        end else if (in_busy) begin
            in_cnt <= in_cnt + 1'b1;
            if (in_cnt == jpeg_coef_pkg::last_idx) in_busy <= 1'b0; // 64th done
        end
    end

    // strobe shift line, q_stb is its last tap
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < lat; i++) stb_pipe[i] <= 1'b0;
        end else begin
            stb_pipe[0] <= in_stb;
            for (int i = 1; i < lat; i++) stb_pipe[i] <= stb_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        idx_pipe[0] <= {cur_idx[2:0], cur_idx[5:3]}; // transposed to natural
        for (int i = 1; i < lat; i++) idx_pipe[i] <= idx_pipe[i-1];
    end

    // stage 1 holds the coefficient while the table is read
    assign rd_addr = {blk_tsel, blk_ctype, idx_pipe[0]};

    // dc only joins coefficient 0
    assign dc_x8  = stb_pipe[0] && (idx_pipe[0] == '0) ? {{2{blk_dc[8]}}, blk_dc, 3'b000} : '0;
    assign s1_sum = {s1_coef[jpeg_coef_pkg::coef_w-1], s1_coef} + dc_x8;
    assign s1_abs = s1_sum[sum_w-1] ? -s1_sum : s1_sum;

    // round half up, then clamp to 4095
    assign rnd_sum = {1'b0, s3_prod} + (prod_w+1)'(32'h8000);
    assign rnd_q   = rnd_sum[prod_w:16];
    assign q_mag   = (rnd_q > {2'b00, jpeg_coef_pkg::mag_max}) ? jpeg_coef_pkg::mag_max
                                                               : rnd_q[11:0];

    always_ff @(posedge clk) begin
        s1_coef <= coef_in;                  // stage 1
        s2_sign <= s1_sum[sum_w-1];          // stage 2, sign and magnitude
        s2_mag  <= s1_abs[abs_w-1:0];        // full magnitude, no clamp yet
        s3_sign <= s2_sign;                  // stage 3, reciprocal product
        s3_prod <= s2_mag * rd_data;
        if (q_mag == '0) begin               // stage 4, no negative zero
            q_val <= '0;
        end else begin
            q_val <= s3_sign ? -$signed({1'b0, q_mag}) : $signed({1'b0, q_mag});
        end
    end

    assign q_stb = stb_pipe[lat-1];
    assign q_idx = idx_pipe[lat-1];

    // blocks need 64 clean cycles of input
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        block_start |-> !in_busy)
        else $error("block_start during block entry");

endmodule

`default_nettype wire

// ==== hdl/zigzag_reorder.sv ====
// zigzag_reorder, two-page buffer written at zigzag positions and read out in scan order
`timescale 1ns/1ps
`default_nettype none

module zigzag_reorder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 q_stb,
    input  jpeg_coef_pkg::idx_t  q_idx,        // natural index
    input  jpeg_coef_pkg::qval_t q_val,
    input  logic                 blk_first_in, // head descriptor flag
    output logic                 out_start,
    output logic                 out_valid,
    output jpeg_coef_pkg::qval_t out_val,
    output logic                 out_first
);

    `include "zigzag_order.svh"

    typedef enum logic {
        st_idle,
        st_reading
    } rd_state_t;

    localparam int page_w = jpeg_coef_pkg::idx_w + 1; // page bit over position

    jpeg_coef_pkg::qval_t page_mem [2 * jpeg_coef_pkg::block_len];

    logic                wpage;    // page being filled
    logic                rpage;    // page being streamed
    jpeg_coef_pkg::idx_t wcnt;     // writes into current page
    logic                last_wr;  // 64th value of a block
    logic                first_lat;
    rd_state_t           rd_state;
    jpeg_coef_pkg::idx_t rd_pos;   // next position to stream
    logic [page_w-1:0]   rd_sel;

    assign last_wr = q_stb && (wcnt == jpeg_coef_pkg::last_idx);
    assign rd_sel  = last_wr ? {wpage, 6'd0} : {rpage, rd_pos}; // new page starts at 0

    always_ff @(posedge clk) begin
        if (q_stb) begin
            page_mem[{wpage, zigzag_pos(q_idx)}] <= q_val;
        end
        if (q_stb && (wcnt == '0)) begin
            first_lat <= blk_first_in; // still this block's descriptor
        end
        out_val <= page_mem[rd_sel]; // registered read
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wpage     <= 1'b0;
            rpage     <= 1'b0;
            wcnt      <= '0;
            rd_state  <= st_idle;
            rd_pos    <= '0;
            out_start <= 1'b0;
            out_valid <= 1'b0;
            out_first <= 1'b0;
        end else begin
            if (q_stb) wcnt <= wcnt + 1'b1; // wraps after 63
            out_start <= last_wr;
            if (last_wr) begin
                wpage     <= ~wpage;  // next block to other page
                rpage     <= wpage;
                rd_pos    <= 6'd1;
                rd_state  <= st_reading;
                out_valid <= 1'b1;
                out_first <= first_lat;
            end else begin
                case (rd_state)
                    st_reading: begin
                        if (rd_pos == '0) begin // 64 values out
                            rd_state  <= st_idle;
                            out_valid <= 1'b0;
                        end else begin
                            rd_pos <= rd_pos + 1'b1;
                        end
                    end
                    default: out_valid <= 1'b0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/jpeg_quantizer.sv ====
// jpeg_quantizer top, descriptor queue, table memory, quantizing datapath and zigzag buffer
`timescale 1ns/1ps
`default_nettype none

module jpeg_quantizer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tw_stb,      // table write
    input  quant_ctrl_pkg::taddr_t tw_addr,
    input  jpeg_coef_pkg::recip_t  tw_data,
    input  logic                   desc_stb,    // block descriptor
    input  jpeg_coef_pkg::dc_t     desc_dc,
    input  quant_ctrl_pkg::ctype_t desc_ctype,
    input  quant_ctrl_pkg::tsel_t  desc_tsel,
    input  logic                   desc_first,
    input  logic                   block_start, // coefficient stream
    input  jpeg_coef_pkg::coef_t   coef_in,
    output logic                   out_start,   // zigzag output
    output logic                   out_valid,
    output jpeg_coef_pkg::qval_t   out_val,
    output logic                   out_first
);

    jpeg_coef_pkg::dc_t     head_dc;
    quant_ctrl_pkg::ctype_t head_ctype;
    quant_ctrl_pkg::tsel_t  head_tsel;
    logic                   head_first;
    quant_ctrl_pkg::taddr_t rd_addr;
    jpeg_coef_pkg::recip_t  rd_data;
    logic                   q_stb;
    jpeg_coef_pkg::idx_t    q_idx;
    jpeg_coef_pkg::qval_t   q_val;

    block_desc_queue u_desc_queue (
        .clk        (clk),
        .rst        (rst),
        .desc_stb   (desc_stb),
        .desc_dc    (desc_dc),
        .desc_ctype (desc_ctype),
        .desc_tsel  (desc_tsel),
        .desc_first (desc_first),
        .pop        (block_start), // descriptor taken at block start
        .head_dc    (head_dc),
        .head_ctype (head_ctype),
        .head_tsel  (head_tsel),
        .head_first (head_first),
        .empty      ()             // checked inside the queue
    );

    quant_table_ram u_table (
        .clk     (clk),
        .tw_stb  (tw_stb),
        .tw_addr (tw_addr),
        .tw_data (tw_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    quant_datapath u_datapath (
        .clk         (clk),
        .rst         (rst),
        .block_start (block_start),
        .coef_in     (coef_in),
        .blk_dc      (head_dc),
        .blk_ctype   (head_ctype),
        .blk_tsel    (head_tsel),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .q_stb       (q_stb),
        .q_idx       (q_idx),
        .q_val       (q_val)
    );

    zigzag_reorder u_reorder (
        .clk          (clk),
        .rst          (rst),
        .q_stb        (q_stb),
        .q_idx        (q_idx),
        .q_val        (q_val),
        .blk_first_in (head_first),
        .out_start    (out_start),
        .out_valid    (out_valid),
        .out_val      (out_val),
        .out_first    (out_first)
    );

endmodule

`default_nettype wire

// ==== test/tb_jpeg_quantizer.sv ====
// tb_jpeg_quantizer, directed tests, quantizer reference model, zigzag table, output monitor
`timescale 1ns/1ps
`default_nettype none

module tb_jpeg_quantizer;

    localparam int drain_limit   = 2000; // cycles allowed for a burst to leave
    localparam int max_blocks    = 8;
    localparam int start_latency = 68;   // block_start to out_start

    logic                   clk;
    logic                   rst;
    logic                   tw_stb;
    quant_ctrl_pkg::taddr_t tw_addr;
    jpeg_coef_pkg::recip_t  tw_data;
    logic                   desc_stb;
    jpeg_coef_pkg::dc_t     desc_dc;
    quant_ctrl_pkg::ctype_t desc_ctype;
    quant_ctrl_pkg::tsel_t  desc_tsel;
    logic                   desc_first;
    logic                   block_start;
    jpeg_coef_pkg::coef_t   coef_in;
    logic                   out_start;
    logic                   out_valid;
    jpeg_coef_pkg::qval_t   out_val;
    logic                   out_first;

    integer seed;
    int     cycle = 0;   // posedges so far
    int     run_len = 0; // out_valid cycles since last out_start
    int     zz_of_nat [64];
    jpeg_coef_pkg::recip_t tbl [quant_ctrl_pkg::table_words]; // model copy of the table

    jpeg_coef_pkg::coef_t   stim_coef  [max_blocks][64]; // input (transposed) order
    jpeg_coef_pkg::dc_t     stim_dc    [max_blocks];
    quant_ctrl_pkg::ctype_t stim_ctype [max_blocks];
    quant_ctrl_pkg::tsel_t  stim_tsel  [max_blocks];
    logic                   stim_first [max_blocks];

    jpeg_coef_pkg::qval_t exp_vals  [$]; // zigzag order, all blocks in flight
    logic                 exp_first [$];
    int                   exp_start [$]; // cycle count while block_start is driven

    jpeg_quantizer uut (
        .clk         (clk),
        .rst         (rst),
        .tw_stb      (tw_stb),
        .tw_addr     (tw_addr),
        .tw_data     (tw_data),
        .desc_stb    (desc_stb),
        .desc_dc     (desc_dc),
        .desc_ctype  (desc_ctype),
        .desc_tsel   (desc_tsel),
        .desc_first  (desc_first),
        .block_start (block_start),
        .coef_in     (coef_in),
        .out_start   (out_start),
        .out_valid   (out_valid),
        .out_val     (out_val),
        .out_first   (out_first)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "testbench stopped at first error");
    endtask

    task automatic check_qval(input string name, input jpeg_coef_pkg::qval_t got,
                              input jpeg_coef_pkg::qval_t exp);
        if (got !== exp)
            stop_on_error($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp)
            stop_on_error($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    // jpeg zigzag walks the anti-diagonals, alternating direction
    task automatic build_zigzag();
        int pos;
        int r;
        pos = 0;
        for (int s = 0; s < 15; s++) begin
            for (int k = 0; k < 8; k++) begin
                r = (s % 2 == 0) ? 7 - k : k; // even diagonals go up and right
                if (r <= s && s - r < 8) begin
                    zz_of_nat[r * 8 + s - r] = pos;
                    pos++;
                end
            end
        end
    endtask

    function automatic jpeg_coef_pkg::qval_t model_quant(input jpeg_coef_pkg::coef_t c,
            input jpeg_coef_pkg::dc_t dc, input logic add_dc, input jpeg_coef_pkg::recip_t r);
        int     sum;
        longint mag;
        longint q;
        sum = int'(c) + (add_dc ? 8 * int'(dc) : 0);
        mag = (sum < 0) ? -sum : sum;
        q   = (mag * longint'(r) + 32768) >>> 16; // round half up
        if (q > 4095) q = 4095;
        model_quant = (sum < 0) ? jpeg_coef_pkg::qval_t'(-q) : jpeg_coef_pkg::qval_t'(q);
    endfunction

    // output monitor, sampled away from the active edge
    always @(negedge clk) begin
        if (!rst) begin
            if (out_start) begin
                check_bit("out_valid", out_valid, 1'b1);
                if (run_len != 0 && run_len != 64) stop_on_error("out_start cut a readout short");
                if (exp_start.size() == 0) stop_on_error("out_start with no block sent");
                check_cycles("out_start latency", cycle - exp_start.pop_front(), start_latency);
                check_bit("out_first", out_first, exp_first.pop_front());
                run_len = 0;
            end
            if (out_valid) begin
                if (exp_vals.size() == 0) stop_on_error("out_valid with no value expected");
                check_qval("out_val", out_val, exp_vals.pop_front());
                run_len++;
                if (run_len > 64) stop_on_error("out_valid ran past 64 values");
            end else begin
                if (run_len != 0 && run_len != 64) stop_on_error("out_valid dropped early");
                run_len = 0;
            end
        end
    end

    task automatic fill_table(input quant_ctrl_pkg::tsel_t ts, input quant_ctrl_pkg::ctype_t ct,
                              input int base, input int step, input logic use_rand);
        for (int n = 0; n < 64; n++) begin
            @(negedge clk);
            tw_stb  = 1'b1;
            tw_addr = {ts, ct, jpeg_coef_pkg::idx_t'(n)}; // natural index
            tw_data = use_rand ? jpeg_coef_pkg::recip_t'($random(seed))
                               : jpeg_coef_pkg::recip_t'(base + step * n);
            tbl[tw_addr] = tw_data;
        end
        @(negedge clk);
        tw_stb = 1'b0;
    endtask

    task automatic queue_descs(input int nblk);
        for (int b = 0; b < nblk; b++) begin
            @(negedge clk);
            desc_stb   = 1'b1;
            desc_dc    = stim_dc[b];
            desc_ctype = stim_ctype[b];
            desc_tsel  = stim_tsel[b];
            desc_first = stim_first[b];
        end
        @(negedge clk);
        desc_stb = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_vals.size() != 0 || exp_start.size() != 0) && waited < drain_limit) begin
            @(negedge clk);
            waited++;
        end
        if (exp_vals.size() != 0 || exp_start.size() != 0)
            stop_on_error("timeout waiting for out_start and the block output");
        repeat (4) @(negedge clk); // out_valid falls
    endtask

    // queue descriptors, stream blocks back to back, wait for all outputs
    task automatic run_blocks(input int nblk);
        jpeg_coef_pkg::qval_t blk_exp [64];
        int nat;
        int addr;
        queue_descs(nblk);
        for (int b = 0; b < nblk; b++) begin
            for (int n = 0; n < 64; n++) begin
                nat  = (n % 8) * 8 + n / 8; // row n mod 8, column n div 8
                addr = int'(stim_tsel[b]) * 128 + int'(stim_ctype[b]) * 64 + nat;
                blk_exp[zz_of_nat[nat]] = model_quant(stim_coef[b][n], stim_dc[b], n == 0,
                                                      tbl[addr]);
            end
            for (int p = 0; p < 64; p++) exp_vals.push_back(blk_exp[p]);
            exp_first.push_back(stim_first[b]);
            for (int n = 0; n < 64; n++) begin
                @(negedge clk);
                if (n == 0) exp_start.push_back(cycle);
                block_start = (n == 0);
                coef_in     = stim_coef[b][n];
            end
        end
        @(negedge clk);
        block_start = 1'b0;
        coef_in     = '0;
        wait_drain();
    endtask

    task automatic test_idle_after_reset();
        repeat (20) begin
            @(negedge clk);
            check_bit("out_valid", out_valid, 1'b0);
            check_bit("out_start", out_start, 1'b0);
        end
    endtask

    task automatic test_unity_table();
        fill_table(3'd0, 1'b0, 'hFFFF, 0, 1'b0); // reciprocal just below 1.0
        stim_dc[0] = '0;
        stim_ctype[0] = 1'b0;
        stim_tsel[0] = 3'd0;
        stim_first[0] = 1'b1;
        for (int n = 0; n < 64; n++) stim_coef[0][n] = jpeg_coef_pkg::coef_t'(n * 3 - 90);
        run_blocks(1);
    endtask

    task automatic test_dc_round_sat();
        fill_table(3'd1, 1'b0, 'h8000, 0, 1'b0); // halves, every odd magnitude rounds
        stim_dc[0] = 9'sd100; // 4000 + 800 saturates
        stim_ctype[0] = 1'b0;
        stim_tsel[0] = 3'd0;
        stim_first[0] = 1'b0;
        stim_dc[1] = -9'sd100; // -4800 halves to -2400, past the 12 bit range
        stim_ctype[1] = 1'b0;
        stim_tsel[1] = 3'd1;
        stim_first[1] = 1'b1;
        for (int n = 0; n < 64; n++) begin
            stim_coef[0][n] = (n == 0) ? 13'sd4000 : jpeg_coef_pkg::coef_t'(-(n * 7));
            stim_coef[1][n] = (n == 0) ? -13'sd4000
                            : jpeg_coef_pkg::coef_t'((n % 2 == 1) ? -(2 * n + 1) : 2 * n + 1);
        end
        run_blocks(2);
    endtask

    task automatic test_two_tables();
        fill_table(3'd2, 1'b0, 'h1000, 'h100, 1'b0);  // luma ramp up
        fill_table(3'd2, 1'b1, 'hC000, -'h200, 1'b0); // chroma ramp down
        for (int b = 0; b < 2; b++) begin
            stim_dc[b] = (b == 0) ? 9'sd5 : -9'sd7;
            stim_ctype[b] = quant_ctrl_pkg::ctype_t'(b);
            stim_tsel[b] = 3'd2;
            stim_first[b] = 1'b0;
            for (int n = 0; n < 64; n++) stim_coef[b][n] = jpeg_coef_pkg::coef_t'(1000 - n * 31);
        end
        run_blocks(2);
    endtask

    task automatic test_back_to_back();
        for (int b = 0; b < 4; b++) begin
            stim_dc[b] = jpeg_coef_pkg::dc_t'(b * 10 - 15);
            stim_ctype[b] = 1'b0;
            stim_tsel[b] = quant_ctrl_pkg::tsel_t'(b % 2); // tables 0 and 1
            stim_first[b] = (b == 1); // only one flagged block
            for (int n = 0; n < 64; n++)
                stim_coef[b][n] = jpeg_coef_pkg::coef_t'(b * 200 + n * 9 - 300);
        end
        run_blocks(4);
    endtask

    task automatic test_random_blocks();
        fill_table(3'd3, 1'b0, 0, 0, 1'b1);
        fill_table(3'd3, 1'b1, 0, 0, 1'b1);
        for (int b = 0; b < 6; b++) begin
            stim_dc[b] = jpeg_coef_pkg::dc_t'($random(seed) % 256); // |sum| stays under 4096
            stim_ctype[b] = quant_ctrl_pkg::ctype_t'($random(seed));
            stim_tsel[b] = 3'd3;
            stim_first[b] = (b == 0);
            for (int n = 0; n < 64; n++)
                stim_coef[b][n] = jpeg_coef_pkg::coef_t'($random(seed) % 2048);
        end
        run_blocks(6);
    endtask

    initial begin
        seed        = 70;
        clk         = 1'b0;
        rst         = 1'b1;
        tw_stb      = 1'b0;
        tw_addr     = '0;
        tw_data     = '0;
        desc_stb    = 1'b0;
        desc_dc     = '0;
        desc_ctype  = 1'b0;
        desc_tsel   = '0;
        desc_first  = 1'b0;
        block_start = 1'b0;
        coef_in     = '0;
        build_zigzag();
        repeat (3) @(posedge clk); // reset for three cycles
        @(negedge clk);
        rst = 1'b0;
        test_idle_after_reset();
        test_unity_table();
        test_dc_round_sat();
        test_two_tables();
        test_back_to_back();
        test_random_blocks();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
hdl/jpeg_coef_pkg.sv
hdl/quant_ctrl_pkg.sv
hdl/block_desc_queue.sv
hdl/quant_table_ram.sv
hdl/quant_datapath.sv
hdl/zigzag_reorder.sv
hdl/jpeg_quantizer.sv
test/tb_jpeg_quantizer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the quantizer testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f filelist.f --top-module tb_jpeg_quantizer -o tb_jpeg_quantizer

status=0
./obj_dir/tb_jpeg_quantizer > sim.log 2>&1 || status=$?
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
